// File: hw/lc3b_defs.svh
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// first fetch address after reset
`define LC3B_PC_RESET 16'h0000

// depth of each memory in 16-bit words
`define LC3B_MEM_WORDS 256

`endif

// File: hw/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

typedef logic [15:0] lc3b_word;  // data or address word
typedef logic [2:0] lc3b_reg;    // register index
typedef logic [2:0] lc3b_nzp;    // n, z, p flags
typedef logic [8:0] lc3b_imm;    // low instruction bits, widest offset is 9

// LC-3b opcodes, only the supported subset is named
typedef enum logic [3:0]
{
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001,
    op_shf = 4'b1101,
    op_lea = 4'b1110
} lc3b_opcode;

endpackage : lc3b_isa_pkg

// File: hw/lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

import lc3b_isa_pkg::*;

typedef enum logic [2:0]
{
    alu_add,
    alu_and,
    alu_not,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass
} lc3b_aluop;

typedef struct packed
{
    lc3b_opcode opcode;
    lc3b_aluop  aluop;
    logic [1:0] imm_sel;      // 00 reg, 01 sext imm5, 10 offset6 x2, 11 zext imm4
    logic       load_regfile;
    logic       load_cc;
    logic       mem_read;
    logic       mem_write;
    logic       is_branch;
    logic [1:0] result_sel;   // 00 alu, 01 memory, 10 offset adder
    logic       is_nop;
} lc3b_ctrl_word;

typedef struct packed
{
    lc3b_ctrl_word ctrl;
    lc3b_word      pc_plus2;
    lc3b_reg       sr1;
    lc3b_reg       sr2;
    lc3b_word      sr1_val;
    lc3b_word      sr2_val;
    lc3b_reg       dest;
    lc3b_imm       imm;
    lc3b_nzp       nzp;
} lc3b_dec_out;

typedef struct packed
{
    lc3b_ctrl_word ctrl;
    lc3b_word      alu_result;
    lc3b_word      mem_addr;     // also carries the LEA address
    lc3b_word      store_data;
    lc3b_reg       dest;
} lc3b_exe_out;

typedef struct packed
{
    logic     we;
    lc3b_reg  dest;
    lc3b_word value;
} lc3b_wb_bus;

endpackage : lc3b_pipe_pkg

// File: hw/lc3b_regfile.sv
`timescale 1ns/1ps

module lc3b_regfile
(
    input  logic                       clk,
    input  logic                       reset,
    input  lc3b_pipe_pkg::lc3b_wb_bus  wb,
    input  lc3b_isa_pkg::lc3b_reg      src_a,
    input  lc3b_isa_pkg::lc3b_reg      src_b,
    output lc3b_isa_pkg::lc3b_word     reg_a,
    output lc3b_isa_pkg::lc3b_word     reg_b
);

import lc3b_isa_pkg::*;

lc3b_word regs [8];

always_ff @(posedge clk)
begin
    if (reset)
    begin
        for (int i = 0; i < 8; i++)
            regs[i] <= '0;
    end
    else if (wb.we)
    begin
        regs[wb.dest] <= wb.value;
    end
end

// write-through so decode sees the retiring value
assign reg_a = (wb.we && wb.dest == src_a) ? wb.value : regs[src_a];
assign reg_b = (wb.we && wb.dest == src_b) ? wb.value : regs[src_b];

endmodule : lc3b_regfile

// File: hw/lc3b_decode.sv
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module lc3b_decode
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         advance,
    input  lc3b_isa_pkg::lc3b_word       instr_rdata,
    input  logic                         branch_taken,
    input  lc3b_isa_pkg::lc3b_word       branch_target,
    input  lc3b_pipe_pkg::lc3b_ctrl_word exe_ctrl,
    input  lc3b_isa_pkg::lc3b_reg        exe_dest,
    input  lc3b_isa_pkg::lc3b_word       reg_a,
    input  lc3b_isa_pkg::lc3b_word       reg_b,
    output lc3b_isa_pkg::lc3b_reg        src_a,
    output lc3b_isa_pkg::lc3b_reg        src_b,
    output lc3b_isa_pkg::lc3b_word       instr_address,
    output lc3b_pipe_pkg::lc3b_dec_out   dec
);

import lc3b_isa_pkg::*;
import lc3b_pipe_pkg::*;

lc3b_word pc;        // next fetch, also pc + 2 of the word in ir
lc3b_word ir;
lc3b_opcode opcode;
lc3b_ctrl_word ctrl;
logic use_a;
logic use_b;
logic bubble;

assign opcode = lc3b_opcode'(ir[15:12]);
assign instr_address = pc;
assign src_a = ir[8:6];
assign src_b = (opcode == op_str) ? ir[11:9] : ir[2:0];  // STR source sits in the dest field

// control word lookup
always_comb
begin
    ctrl = '0;
    ctrl.opcode = opcode;
    ctrl.aluop = alu_pass;
    use_a = 1'b1;
    use_b = 1'b0;
    case (opcode)
        op_add, op_and:
        begin
            ctrl.aluop = (opcode == op_and) ? alu_and : alu_add;
            ctrl.imm_sel = ir[5] ? 2'b01 : 2'b00;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
            use_b = ~ir[5];
        end
        op_not:
        begin
            ctrl.aluop = alu_not;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end
        op_shf:
        begin
            if (!ir[4])
                ctrl.aluop = alu_sll;
            else if (ir[5])
                ctrl.aluop = alu_sra;
            else
                ctrl.aluop = alu_srl;
            ctrl.imm_sel = 2'b11;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
        end
        op_lea:
        begin
            ctrl.result_sel = 2'b10;
            ctrl.load_regfile = 1'b1;  // LC-3b LEA leaves cc alone
            use_a = 1'b0;
        end
        op_br:
        begin
            ctrl.is_branch = 1'b1;
            use_a = 1'b0;
        end
        op_ldr:
        begin
            ctrl.aluop = alu_add;
            ctrl.imm_sel = 2'b10;
            ctrl.mem_read = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.load_cc = 1'b1;
            ctrl.result_sel = 2'b01;
        end
        op_str:
        begin
            ctrl.aluop = alu_add;
            ctrl.imm_sel = 2'b10;
            ctrl.mem_write = 1'b1;
            use_b = 1'b1;
        end
        default:
        begin
            ctrl.is_nop = 1'b1;  // unsupported opcode
            use_a = 1'b0;
        end
    endcase
    if (ir == 16'h0000)
    begin
        ctrl.is_branch = 1'b0;  // flushed or reset slot
        ctrl.is_nop = 1'b1;
        use_a = 1'b0;
    end
end

// load in execute feeding this instruction
assign bubble = exe_ctrl.mem_read && !exe_ctrl.is_nop && !ctrl.is_nop
                && ((use_a && src_a == exe_dest) || (use_b && src_b == exe_dest));

always_comb
begin
    dec.ctrl = ctrl;
    if (bubble || branch_taken)
    begin
        dec.ctrl = '0;
        dec.ctrl.is_nop = 1'b1;
    end
    dec.pc_plus2 = pc;
    dec.sr1 = src_a;
    dec.sr2 = src_b;
    dec.sr1_val = reg_a;
    dec.sr2_val = reg_b;
    dec.dest = ir[11:9];
    dec.imm = ir[8:0];
    dec.nzp = ir[11:9];
end

always_ff @(posedge clk)
begin
    if (reset)
    begin
        pc <= `LC3B_PC_RESET;
        ir <= '0;
    end
    else if (advance)
    begin
        if (branch_taken)
        begin
            pc <= branch_target;
            ir <= '0;          // drop the word fetched on the wrong path
        end
        else if (!bubble)
        begin
            pc <= pc + 16'd2;
            ir <= instr_rdata;
        end
    end
end

endmodule : lc3b_decode

// File: hw/lc3b_execute.sv
`timescale 1ns/1ps

module lc3b_execute
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         advance,
    input  lc3b_pipe_pkg::lc3b_dec_out   dec,
    input  lc3b_pipe_pkg::lc3b_wb_bus    wb,
    input  lc3b_pipe_pkg::lc3b_wb_bus    res_fwd,
    output lc3b_pipe_pkg::lc3b_ctrl_word exe_ctrl,
    output lc3b_isa_pkg::lc3b_reg        exe_dest,
    output logic                         branch_taken,
    output lc3b_isa_pkg::lc3b_word       branch_target,
    output lc3b_pipe_pkg::lc3b_exe_out   exe
);

import lc3b_isa_pkg::*;
import lc3b_pipe_pkg::*;

lc3b_dec_out dec_q;
lc3b_word opnd_a;
lc3b_word reg_b_fwd;
lc3b_word opnd_b;
lc3b_word alu_out;
lc3b_word off_sum;
lc3b_word imm5;
lc3b_word off6;
lc3b_word imm4;
lc3b_word off9;
lc3b_nzp cc_q;
lc3b_nzp cc_now;
logic res_cc;        // instruction now in result stage sets cc

function automatic lc3b_word forward(input lc3b_reg idx, input lc3b_word val,
                                     input lc3b_wb_bus near, input lc3b_wb_bus far);
    if (near.we && near.dest == idx)
        return near.value;
    if (far.we && far.dest == idx)
        return far.value;
    return val;
endfunction

function automatic lc3b_nzp gen_nzp(input lc3b_word v);
    return {v[15], v == 16'h0000, !v[15] && v != 16'h0000};
endfunction

always_ff @(posedge clk)
begin
    if (reset)
    begin
        dec_q.ctrl <= '0;
        dec_q.ctrl.is_nop <= 1'b1;
        res_cc <= 1'b0;
        cc_q <= 3'b010;      // registers reset to zero
    end
    else
    begin
        cc_q <= cc_now;
        if (advance)
        begin
            dec_q <= dec;
            res_cc <= dec_q.ctrl.load_cc && !dec_q.ctrl.is_nop;
        end
    end
end

assign opnd_a = forward(dec_q.sr1, dec_q.sr1_val, res_fwd, wb);
assign reg_b_fwd = forward(dec_q.sr2, dec_q.sr2_val, res_fwd, wb);

assign imm5 = {{11{dec_q.imm[4]}}, dec_q.imm[4:0]};
assign off6 = {{9{dec_q.imm[5]}}, dec_q.imm[5:0], 1'b0};
assign imm4 = {12'h000, dec_q.imm[3:0]};
assign off9 = {{6{dec_q.imm[8]}}, dec_q.imm[8:0], 1'b0};

always_comb
begin
    case (dec_q.ctrl.imm_sel)
        2'b01:   opnd_b = imm5;
        2'b10:   opnd_b = off6;
        2'b11:   opnd_b = imm4;
        default: opnd_b = reg_b_fwd;
    endcase
end

// ALU and shifter
always_comb
begin
    case (dec_q.ctrl.aluop)
        alu_add: alu_out = opnd_a + opnd_b;
        alu_and: alu_out = opnd_a & opnd_b;
        alu_not: alu_out = ~opnd_a;
        alu_sll: alu_out = opnd_a << opnd_b[3:0];
        alu_srl: alu_out = opnd_a >> opnd_b[3:0];
        alu_sra: alu_out = lc3b_word'($signed(opnd_a) >>> opnd_b[3:0]);
        default: alu_out = opnd_a;
    endcase
end

assign off_sum = dec_q.pc_plus2 + off9;  // BR target and LEA address

// cc of the instruction retiring this cycle wins over the stored copy
assign cc_now = (wb.we && res_cc) ? gen_nzp(wb.value) : cc_q;

assign branch_taken = dec_q.ctrl.is_branch && !dec_q.ctrl.is_nop
                      && |(dec_q.nzp & cc_now);
assign branch_target = off_sum;

assign exe_ctrl = dec_q.ctrl;
assign exe_dest = dec_q.dest;

always_comb
begin
    exe.ctrl = dec_q.ctrl;
    exe.alu_result = alu_out;
    exe.mem_addr = (dec_q.ctrl.result_sel == 2'b10) ? off_sum : alu_out;
    exe.store_data = reg_b_fwd;
    exe.dest = dec_q.dest;
end

endmodule : lc3b_execute

// File: hw/lc3b_result.sv
`timescale 1ns/1ps

module lc3b_result
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_mem_resp,
    input  lc3b_pipe_pkg::lc3b_exe_out exe,
    input  lc3b_isa_pkg::lc3b_word     mem_rdata,
    input  logic                       d_mem_resp,
    output logic                       mem_read,
    output logic                       mem_write,
    output lc3b_isa_pkg::lc3b_word     mem_address,
    output lc3b_isa_pkg::lc3b_word     mem_wdata,
    output logic                       advance,
    output lc3b_pipe_pkg::lc3b_wb_bus  res_fwd,
    output lc3b_pipe_pkg::lc3b_wb_bus  wb
);

import lc3b_isa_pkg::*;
import lc3b_pipe_pkg::*;

lc3b_exe_out exe_q;
logic mem_op;
logic d_done;        // data access finished, waiting on fetch
lc3b_word load_q;
lc3b_word load_word;
lc3b_word wb_value;

assign mem_op = exe_q.ctrl.mem_read || exe_q.ctrl.mem_write;

// strobes held until the response, not repeated after it
assign mem_read = exe_q.ctrl.mem_read && !d_done;
assign mem_write = exe_q.ctrl.mem_write && !d_done;
assign mem_address = exe_q.mem_addr;
assign mem_wdata = exe_q.store_data;

assign advance = i_mem_resp && (d_mem_resp || d_done || !mem_op);

always_ff @(posedge clk)
begin
    if (reset)
    begin
        exe_q.ctrl <= '0;
        exe_q.ctrl.is_nop <= 1'b1;
        d_done <= 1'b0;
    end
    else if (advance)
    begin
        exe_q <= exe;
        d_done <= 1'b0;
    end
    else if (mem_op && d_mem_resp)
    begin
        d_done <= 1'b1;
    end
end

// keep the loaded word while fetch is still stalled
always_ff @(posedge clk)
begin
    if (exe_q.ctrl.mem_read && d_mem_resp && !d_done)
        load_q <= mem_rdata;
end

assign load_word = d_done ? load_q : mem_rdata;

always_comb
begin
    case (exe_q.ctrl.result_sel)
        2'b01:   wb_value = load_word;
        2'b10:   wb_value = exe_q.mem_addr;   // LEA
        default: wb_value = exe_q.alu_result;
    endcase
end

always_comb
begin
    res_fwd.we = exe_q.ctrl.load_regfile && !exe_q.ctrl.mem_read && !exe_q.ctrl.is_nop;
    res_fwd.dest = exe_q.dest;
    res_fwd.value = wb_value;
    wb.we = exe_q.ctrl.load_regfile && !exe_q.ctrl.is_nop && advance;
    wb.dest = exe_q.dest;
    wb.value = wb_value;
end

endmodule : lc3b_result

// File: hw/lc3b_pipeline.sv
`timescale 1ns/1ps

module lc3b_pipeline
(
    input  logic                   clk,
    input  logic                   reset,
    output logic                   instr_read,
    output lc3b_isa_pkg::lc3b_word instr_address,
    input  lc3b_isa_pkg::lc3b_word instr_rdata,
    input  logic                   i_mem_resp,
    output logic                   mem_read,
    output logic                   mem_write,
    output lc3b_isa_pkg::lc3b_word mem_address,
    output lc3b_isa_pkg::lc3b_word mem_wdata,
    input  lc3b_isa_pkg::lc3b_word mem_rdata,
    input  logic                   d_mem_resp
);

import lc3b_isa_pkg::*;
import lc3b_pipe_pkg::*;

logic advance;
logic branch_taken;
lc3b_word branch_target;
lc3b_ctrl_word exe_ctrl;
lc3b_reg exe_dest;
lc3b_reg src_a;
lc3b_reg src_b;
lc3b_word reg_a;
lc3b_word reg_b;
lc3b_dec_out dec;
lc3b_exe_out exe;
lc3b_wb_bus res_fwd;
lc3b_wb_bus wb;

assign instr_read = 1'b1;  // fetch runs every cycle

lc3b_decode decode_i
(
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .instr_rdata(instr_rdata),
    .branch_taken(branch_taken),
    .branch_target(branch_target),
    .exe_ctrl(exe_ctrl),
    .exe_dest(exe_dest),
    .reg_a(reg_a),
    .reg_b(reg_b),
    .src_a(src_a),
    .src_b(src_b),
    .instr_address(instr_address),
    .dec(dec)
);

lc3b_execute execute_i
(
    .clk(clk),
    .reset(reset),
    .advance(advance),
    .dec(dec),
    .wb(wb),
    .res_fwd(res_fwd),
    .exe_ctrl(exe_ctrl),
    .exe_dest(exe_dest),
    .branch_taken(branch_taken),
    .branch_target(branch_target),
    .exe(exe)
);

lc3b_result result_i
(
    .clk(clk),
    .reset(reset),
    .i_mem_resp(i_mem_resp),
    .exe(exe),
    .mem_rdata(mem_rdata),
    .d_mem_resp(d_mem_resp),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata),
    .advance(advance),
    .res_fwd(res_fwd),
    .wb(wb)
);

lc3b_regfile regfile_i
(
    .clk(clk),
    .reset(reset),
    .wb(wb),
    .src_a(src_a),
    .src_b(src_b),
    .reg_a(reg_a),
    .reg_b(reg_b)
);

endmodule : lc3b_pipeline

// File: test/lc3b_mem_model.sv
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module lc3b_mem_model
(
    input  logic                   clk,
    input  logic                   clear,        // refill both memories, reset delays
    input  logic                   delay_en,
    input  logic                   load_en,
    input  logic                   load_dmem,    // 1 data memory, 0 instruction memory
    input  lc3b_isa_pkg::lc3b_word load_addr,
    input  lc3b_isa_pkg::lc3b_word load_data,
    input  logic                   instr_read,
    input  lc3b_isa_pkg::lc3b_word instr_address,
    output lc3b_isa_pkg::lc3b_word instr_rdata,
    output logic                   i_mem_resp,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  lc3b_isa_pkg::lc3b_word mem_address,
    input  lc3b_isa_pkg::lc3b_word mem_wdata,
    output lc3b_isa_pkg::lc3b_word mem_rdata,
    output logic                   d_mem_resp
);

import lc3b_isa_pkg::*;

localparam int AW = $clog2(`LC3B_MEM_WORDS);

lc3b_word imem [`LC3B_MEM_WORDS];
lc3b_word dmem [`LC3B_MEM_WORDS];
logic [1:0] i_wait;     // cycles left before the fetch response
logic [1:0] d_wait;
logic hold;

function automatic logic [1:0] next_delay();
    if (delay_en)
        return 2'($urandom % 4);
    return 2'd0;
endfunction

assign hold = clear || load_en;  // no responses while memories are rewritten
assign instr_rdata = imem[instr_address[AW:1]];
assign mem_rdata = dmem[mem_address[AW:1]];
assign i_mem_resp = instr_read && !hold && i_wait == 2'd0;
assign d_mem_resp = (mem_read || mem_write) && !hold && d_wait == 2'd0;

always @(posedge clk)
begin
    if (clear)
    begin
        for (int i = 0; i < `LC3B_MEM_WORDS; i++)
        begin
            imem[i] <= 16'h0000;                // all nops
            dmem[i] <= 16'hC000 ^ 16'(i * 5);   // address pattern
        end
        i_wait <= 2'd0;
        d_wait <= 2'd0;
    end
    else if (load_en)
    begin
        if (load_dmem)
            dmem[load_addr[AW:1]] <= load_data;
        else
            imem[load_addr[AW:1]] <= load_data;
    end
    else
    begin
        if (i_mem_resp)
            i_wait <= next_delay();
        else if (instr_read && i_wait != 2'd0)
            i_wait <= i_wait - 2'd1;
        if (d_mem_resp)
        begin
            if (mem_write)
                dmem[mem_address[AW:1]] <= mem_wdata;
            d_wait <= next_delay();
        end
        else if ((mem_read || mem_write) && d_wait != 2'd0)
        begin
            d_wait <= d_wait - 2'd1;
        end
    end
end

endmodule : lc3b_mem_model

// File: test/lc3b_pipeline_tb.sv
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module lc3b_pipeline_tb;

import lc3b_isa_pkg::*;

localparam int CLK_PERIOD = 20;
localparam int NPROG = 5;
localparam int NRUNS = 2 * NPROG;      // second pass with random delays
localparam int PROG_WORDS = 14;
localparam int STORE_TIMEOUT = 300;    // cycles to wait for the expected stores
localparam int SETTLE = 30;            // extra cycles to catch stray stores

logic clk;
logic reset;
logic clear;
logic delay_en;
logic load_en;
logic load_dmem;
lc3b_word load_addr;
lc3b_word load_data;
logic instr_read;
lc3b_word instr_address;
lc3b_word instr_rdata;
logic i_mem_resp;
logic mem_read;
logic mem_write;
lc3b_word mem_address;
lc3b_word mem_wdata;
lc3b_word mem_rdata;
logic d_mem_resp;

// program table
string test_name [NPROG];
lc3b_word prog [NPROG][PROG_WORDS];
int prog_len [NPROG];
lc3b_word pre_addr [NPROG][2];
lc3b_word pre_val [NPROG][2];
int pre_cnt [NPROG];
lc3b_word exp_addr [NPROG][4];
lc3b_word exp_val [NPROG][4];
int exp_cnt [NPROG];

lc3b_word cap_addr [$];
lc3b_word cap_data [$];
int errors;
int checks;
int failed_tests;

lc3b_pipeline dut_i
(
    .clk(clk),
    .reset(reset),
    .instr_read(instr_read),
    .instr_address(instr_address),
    .instr_rdata(instr_rdata),
    .i_mem_resp(i_mem_resp),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .d_mem_resp(d_mem_resp)
);

lc3b_mem_model mem_i
(
    .clk(clk),
    .clear(clear),
    .delay_en(delay_en),
    .load_en(load_en),
    .load_dmem(load_dmem),
    .load_addr(load_addr),
    .load_data(load_data),
    .instr_read(instr_read),
    .instr_address(instr_address),
    .instr_rdata(instr_rdata),
    .i_mem_resp(i_mem_resp),
    .mem_read(mem_read),
    .mem_write(mem_write),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .d_mem_resp(d_mem_resp)
);

initial
begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// instruction encoders
function automatic lc3b_word enc_reg(input lc3b_opcode op, input lc3b_reg dr,
                                     input lc3b_reg sr1, input lc3b_reg sr2);
    return {op, dr, sr1, 3'b000, sr2};
endfunction

function automatic lc3b_word enc_imm(input lc3b_opcode op, input lc3b_reg dr,
                                     input lc3b_reg sr1, input logic [4:0] imm5);
    return {op, dr, sr1, 1'b1, imm5};
endfunction

function automatic lc3b_word enc_not(input lc3b_reg dr, input lc3b_reg sr);
    return {op_not, dr, sr, 6'h3F};
endfunction

function automatic lc3b_word enc_shf(input lc3b_reg dr, input lc3b_reg sr, input logic arith,
                                     input logic right, input logic [3:0] amount);
    return {op_shf, dr, sr, arith, right, amount};
endfunction

function automatic lc3b_word enc_mem(input lc3b_opcode op, input lc3b_reg r,
                                     input lc3b_reg base, input logic [5:0] off6);
    return {op, r, base, off6};
endfunction

function automatic lc3b_word enc_br(input lc3b_nzp nzp, input logic [8:0] off9);
    return {op_br, nzp, off9};
endfunction

function automatic lc3b_word enc_lea(input lc3b_reg dr, input logic [8:0] off9);
    return {op_lea, dr, off9};
endfunction

task automatic add_instr(input int t, input lc3b_word w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

task automatic add_preload(input int t, input lc3b_word a, input lc3b_word v);
    pre_addr[t][pre_cnt[t]] = a;
    pre_val[t][pre_cnt[t]] = v;
    pre_cnt[t]++;
endtask

task automatic add_store(input int t, input lc3b_word a, input lc3b_word v);
    exp_addr[t][exp_cnt[t]] = a;
    exp_val[t][exp_cnt[t]] = v;
    exp_cnt[t]++;
endtask

// expected stores worked out by hand, r6 stays zero as the store base
task automatic build_table();
    for (int t = 0; t < NPROG; t++)
    begin
        prog_len[t] = 0;
        pre_cnt[t] = 0;
        exp_cnt[t] = 0;
    end
    test_name[0] = "alu_chain";
    add_instr(0, enc_imm(op_add, 3'd1, 3'd0, 5'h05));   // r1 = 5
    add_instr(0, enc_reg(op_add, 3'd2, 3'd1, 3'd1));    // r2 = 10
    add_instr(0, enc_imm(op_and, 3'd3, 3'd2, 5'h07));   // r3 = 2
    add_instr(0, enc_not(3'd4, 3'd3));                  // r4 = fffd
    add_instr(0, enc_reg(op_and, 3'd5, 3'd4, 3'd2));    // r5 = 8
    add_instr(0, enc_mem(op_str, 3'd4, 3'd6, 6'd16));
    add_instr(0, enc_mem(op_str, 3'd5, 3'd6, 6'd17));
    add_instr(0, enc_imm(op_add, 3'd5, 3'd5, 5'h1F));   // r5 = 7
    add_instr(0, enc_mem(op_str, 3'd5, 3'd6, 6'd18));
    add_store(0, 16'h0020, 16'hFFFD);
    add_store(0, 16'h0022, 16'h0008);
    add_store(0, 16'h0024, 16'h0007);

    test_name[1] = "shifts";
    add_instr(1, enc_imm(op_add, 3'd1, 3'd0, 5'h13));   // r1 = fff3
    add_instr(1, enc_shf(3'd2, 3'd1, 1'b0, 1'b0, 4'd4));
    add_instr(1, enc_shf(3'd3, 3'd1, 1'b0, 1'b1, 4'd4));
    add_instr(1, enc_shf(3'd4, 3'd1, 1'b1, 1'b1, 4'd2));
    add_instr(1, enc_shf(3'd5, 3'd2, 1'b0, 1'b1, 4'd8));
    for (int i = 0; i < 4; i++)
        add_instr(1, enc_mem(op_str, 3'(i + 2), 3'd6, 6'(16 + i)));
    add_store(1, 16'h0020, 16'hFF30);
    add_store(1, 16'h0022, 16'h0FFF);
    add_store(1, 16'h0024, 16'hFFFC);
    add_store(1, 16'h0026, 16'h00FF);

    test_name[2] = "load_use";
    add_preload(2, 16'h0030, 16'h1234);
    add_preload(2, 16'h0032, 16'h8001);
    add_instr(2, enc_mem(op_ldr, 3'd1, 3'd6, 6'd24));
    add_instr(2, enc_imm(op_add, 3'd2, 3'd1, 5'h05));
    add_instr(2, enc_mem(op_str, 3'd2, 3'd6, 6'd16));
    add_instr(2, enc_mem(op_ldr, 3'd3, 3'd6, 6'd24));
    add_instr(2, enc_mem(op_str, 3'd3, 3'd6, 6'd17));  // store data straight from a load
    add_instr(2, enc_mem(op_ldr, 3'd4, 3'd6, 6'd25));
    add_instr(2, enc_reg(op_add, 3'd5, 3'd4, 3'd4));    // 8001 + 8001 wraps to 2
    add_instr(2, enc_mem(op_str, 3'd5, 3'd6, 6'd18));
    add_store(2, 16'h0020, 16'h1239);
    add_store(2, 16'h0022, 16'h1234);
    add_store(2, 16'h0024, 16'h0002);

    test_name[3] = "branches";
    add_instr(3, enc_imm(op_add, 3'd1, 3'd0, 5'h1E));   // r1 = fffe, n
    add_instr(3, enc_br(3'b100, 9'h001));               // taken
    add_instr(3, enc_mem(op_str, 3'd1, 3'd6, 6'd16));   // skipped
    add_instr(3, enc_br(3'b011, 9'h001));               // not taken
    add_instr(3, enc_mem(op_str, 3'd1, 3'd6, 6'd17));
    add_instr(3, enc_imm(op_and, 3'd2, 3'd1, 5'h00));   // z
    add_instr(3, enc_br(3'b010, 9'h001));
    add_instr(3, enc_mem(op_str, 3'd1, 3'd6, 6'd18));   // skipped
    add_instr(3, enc_imm(op_add, 3'd3, 3'd0, 5'h03));   // p
    add_instr(3, enc_br(3'b001, 9'h001));
    add_instr(3, enc_mem(op_str, 3'd1, 3'd6, 6'd19));   // skipped
    add_instr(3, enc_mem(op_str, 3'd3, 3'd6, 6'd20));
    add_store(3, 16'h0022, 16'hFFFE);
    add_store(3, 16'h0028, 16'h0003);

    test_name[4] = "lea";
    add_instr(4, enc_lea(3'd1, 9'h005));                // 2 + 10
    add_instr(4, enc_mem(op_str, 3'd1, 3'd6, 6'd16));
    add_instr(4, enc_lea(3'd2, 9'h1FE));                // 6 - 4
    add_instr(4, enc_mem(op_str, 3'd2, 3'd6, 6'd17));
    add_instr(4, enc_reg(op_add, 3'd3, 3'd1, 3'd2));
    add_instr(4, enc_mem(op_str, 3'd3, 3'd6, 6'd18));
    add_store(4, 16'h0020, 16'h000C);
    add_store(4, 16'h0022, 16'h0002);
    add_store(4, 16'h0024, 16'h000E);

    for (int t = 0; t < NPROG; t++)
        add_instr(t, enc_br(3'b111, 9'h1FF));           // spin on itself
endtask

task automatic check_value(input string name, input lc3b_word got, input lc3b_word exp);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic load_memories(input int t);
    @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    for (int i = 0; i < prog_len[t]; i++)
    begin
        load_en <= 1'b1;
        load_dmem <= 1'b0;
        load_addr <= `LC3B_PC_RESET + 16'(2 * i);
        load_data <= prog[t][i];
        @(posedge clk);
    end
    for (int i = 0; i < pre_cnt[t]; i++)
    begin
        load_en <= 1'b1;
        load_dmem <= 1'b1;
        load_addr <= pre_addr[t][i];
        load_data <= pre_val[t][i];
        @(posedge clk);
    end
    load_en <= 1'b0;
endtask

// every completed data write
always @(posedge clk)
begin
    if (!reset && mem_write && d_mem_resp)
    begin
        cap_addr.push_back(mem_address);
        cap_data.push_back(mem_wdata);
    end
end

initial
begin
    #(NRUNS * 400 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", NRUNS * 400);
    $display("Done: errors found");
    $finish;
end

initial
begin
    int t;
    int cycles;
    int errs_before;

    reset = 1'b1;
    clear = 1'b0;
    delay_en = 1'b0;
    load_en = 1'b0;
    load_dmem = 1'b0;
    load_addr = '0;
    load_data = '0;
    errors = 0;
    checks = 0;
    failed_tests = 0;
    void'($urandom(83));
    build_table();

    for (int run = 0; run < NRUNS; run++)
    begin
        t = run % NPROG;
        errs_before = errors;
        delay_en <= (run >= NPROG);
        load_memories(t);
        cap_addr.delete();
        cap_data.delete();
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("instr_address", instr_address, `LC3B_PC_RESET);
        check_value("mem_write", 16'(mem_write), 16'h0000);
        check_value("mem_read", 16'(mem_read), 16'h0000);
        check_value("instr_read", 16'(instr_read), 16'h0001);
        cycles = 0;
        while (cap_addr.size() < exp_cnt[t] && cycles < STORE_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        repeat (SETTLE) @(posedge clk);
        if (cap_addr.size() != exp_cnt[t])
        begin
            errors++;
            $display("test %s saw %0d stores where %0d were expected",
                     test_name[t], cap_addr.size(), exp_cnt[t]);
        end
        for (int i = 0; i < exp_cnt[t] && i < cap_addr.size(); i++)
        begin
            check_value($sformatf("mem_address[%0d]", i), cap_addr[i], exp_addr[t][i]);
            check_value($sformatf("mem_wdata[%0d]", i), cap_data[i], exp_val[t][i]);
        end
        if (errors != errs_before)
            failed_tests++;
        $display("test %0d %s delays=%0d: %s", run, test_name[t], run >= NPROG,
                 (errors == errs_before) ? "ok" : "mismatch");
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             NRUNS, failed_tests, checks, errors);
    if (errors == 0)
        $display("Done: no errors");
    else
        $display("Done: errors found");
    $finish;
end

endmodule : lc3b_pipeline_tb

// File: sources.f
+incdir+hw
hw/lc3b_isa_pkg.sv
hw/lc3b_pipe_pkg.sv
hw/lc3b_regfile.sv
hw/lc3b_decode.sv
hw/lc3b_execute.sv
hw/lc3b_result.sv
hw/lc3b_pipeline.sv
test/lc3b_mem_model.sv
test/lc3b_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= lc3b_pipeline_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
PASS_MSG := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
